//--- cache_bus_adapter.sv
// adapter joining icache and dcache request ports to one request/grant memory bus
`include "cache_bus_defs.svh"

module cache_bus_adapter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // icache
  input  logic                        icache_req_i,
  output logic                        icache_ack_o,
  input  cache_bus_pkg::icache_req_t  icache_data_i,
  // dcache
  input  logic                        dcache_req_i,
  output logic                        dcache_ack_o,
  input  cache_bus_pkg::dcache_req_t  dcache_data_i,
  // return packets, consumed in the cycle they are valid
  output logic                        icache_rtrn_vld_o,
  output cache_bus_pkg::icache_rtrn_t icache_rtrn_o,
  output logic                        dcache_rtrn_vld_o,
  output cache_bus_pkg::dcache_rtrn_t dcache_rtrn_o,
  // memory bus
  output cache_bus_pkg::bus_req_t     bus_req_o,
  input  logic                        bus_gnt_i,
  input  cache_bus_pkg::bus_rbeat_t   bus_rbeat_i,
  input  cache_bus_pkg::bus_bresp_t   bus_bresp_i
);

  cache_bus_pkg::icache_req_t icache_head;
  cache_bus_pkg::dcache_req_t dcache_head;
  logic                       icache_full, icache_empty, icache_pop;
  logic                       dcache_full, dcache_empty, dcache_pop;
  logic                       issue_ird, issue_drd, issue_dwr;
  logic [`CB_TID_W-1:0]       issue_tid;
  cache_bus_pkg::meta_full_t  meta_full;

  //////////////////////////////
  // request FIFOs
  //////////////////////////////

  assign icache_ack_o = icache_req_i & ~icache_full;
  assign dcache_ack_o = dcache_req_i & ~dcache_full;

  meta_fifo #(.item_t(cache_bus_pkg::icache_req_t), .depth(`CB_REQ_DEPTH)) u_icache_fifo (
    .clk_i, .rst_ni, .push_i(icache_ack_o), .data_i(icache_data_i), .pop_i(icache_pop),
    .data_o(icache_head), .full_o(icache_full), .empty_o(icache_empty)
  );

  meta_fifo #(.item_t(cache_bus_pkg::dcache_req_t), .depth(`CB_REQ_DEPTH)) u_dcache_fifo (
    .clk_i, .rst_ni, .push_i(dcache_ack_o), .data_i(dcache_data_i), .pop_i(dcache_pop),
    .data_o(dcache_head), .full_o(dcache_full), .empty_o(dcache_empty)
  );

  //////////////////////////////
  // issue and return
  //////////////////////////////

  req_issue u_req_issue (
    .clk_i, .rst_ni,
    .icache_head_i (icache_head),
    .icache_empty_i(icache_empty),
    .dcache_head_i (dcache_head),
    .dcache_empty_i(dcache_empty),
    .meta_full_i   (meta_full),
    .bus_req_o, .bus_gnt_i,
    .icache_pop_o  (icache_pop),
    .dcache_pop_o  (dcache_pop),
    .issue_ird_o   (issue_ird),
    .issue_drd_o   (issue_drd),
    .issue_dwr_o   (issue_dwr),
    .issue_tid_o   (issue_tid)
  );

  rtrn_assembler u_rtrn_assembler (
    .clk_i, .rst_ni,
    .issue_ird_i (issue_ird),
    .issue_drd_i (issue_drd),
    .issue_dwr_i (issue_dwr),
    .issue_tid_i (issue_tid),
    .meta_full_o (meta_full),
    .bus_rbeat_i, .bus_bresp_i,
    .icache_rtrn_vld_o, .icache_rtrn_o,
    .dcache_rtrn_vld_o, .dcache_rtrn_o
  );

endmodule

//--- cache_bus_adapter_props.sv
// bound checks on the cache bus adapter request hold, reset state and store ack timing
module cache_bus_adapter_props (
  input logic                        clk_i,
  input logic                        rst_ni,
  input cache_bus_pkg::bus_req_t     bus_req_i,
  input logic                        bus_gnt_i,
  input cache_bus_pkg::bus_rbeat_t   bus_rbeat_i,
  input logic                        icache_rtrn_vld_i,
  input logic                        dcache_rtrn_vld_i,
  input cache_bus_pkg::dcache_rtrn_t dcache_rtrn_i
);

  // a waiting request keeps every field until the slave grants it
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.valid && !bus_gnt_i |=> $stable(bus_req_i))
    else $error("bus request changed while waiting for grant");

  // nothing comes back right after reset
  rtrn_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !icache_rtrn_vld_i && !dcache_rtrn_vld_i)
    else $error("return valid high in the first cycle after reset");

  // write responses only drain in cycles without a dcache read beat
  store_ack_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rbeat_i.valid && bus_rbeat_i.id |=>
      !(dcache_rtrn_vld_i && dcache_rtrn_i.rtype == cache_bus_pkg::DCACHE_STORE_ACK))
    else $error("store ack decided in a cycle with a dcache read beat");

endmodule

bind cache_bus_adapter cache_bus_adapter_props u_props (
  .clk_i, .rst_ni, .bus_req_i(bus_req_o), .bus_gnt_i, .bus_rbeat_i,
  .icache_rtrn_vld_i(icache_rtrn_vld_o), .dcache_rtrn_vld_i(dcache_rtrn_vld_o),
  .dcache_rtrn_i(dcache_rtrn_o)
);

//--- cache_bus_defs.svh
// cache bus adapter widths and buffer depths shared by package and RTL
`ifndef CACHE_BUS_DEFS_SVH
`define CACHE_BUS_DEFS_SVH

// physical address and bus data width
`define CB_ADDR_W 32
`define CB_DATA_W 64

// cache line, two bus beats
`define CB_LINE_W 128

// transaction id width used by both caches
`define CB_TID_W 2

// request FIFOs in front of the issue stage
`define CB_REQ_DEPTH 2

// tid FIFOs and write response FIFO
`define CB_META_DEPTH 4

`endif

//--- cache_bus_pkg.sv
// cache bus adapter types for cache requests, bus transfers and return packets
`include "cache_bus_defs.svh"

package cache_bus_pkg;

  //////////////////////////////
  // cache side
  //////////////////////////////

  typedef enum logic {
    DCACHE_LOAD_REQ  = 1'b0,
    DCACHE_STORE_REQ = 1'b1
  } dcache_rtype_e;

  typedef enum logic {
    DCACHE_LOAD_ACK  = 1'b0,
    DCACHE_STORE_ACK = 1'b1
  } dcache_rtrn_e;

  typedef struct packed {
    logic [`CB_ADDR_W-1:0] paddr;
    logic                  nc;
    logic [`CB_TID_W-1:0]  tid;
  } icache_req_t;

  typedef struct packed {
    dcache_rtype_e         rtype;
    logic [`CB_ADDR_W-1:0] paddr;
    // size[2] asks for a full line on loads
    logic [2:0]            size;
    logic [`CB_DATA_W-1:0] data;
    logic [`CB_TID_W-1:0]  tid;
  } dcache_req_t;

  typedef struct packed {
    logic [`CB_TID_W-1:0]  tid;
    logic [`CB_LINE_W-1:0] data;
  } icache_rtrn_t;

  typedef struct packed {
    dcache_rtrn_e          rtype;
    logic [`CB_TID_W-1:0]  tid;
    logic [`CB_LINE_W-1:0] data;
  } dcache_rtrn_t;

  //////////////////////////////
  // bus side
  //////////////////////////////

  // id 0 is the icache, id 1 the dcache
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [`CB_ADDR_W-1:0]   addr;
    logic [2:0]              size;
    logic                    blen;
    logic                    id;
    logic [`CB_DATA_W-1:0]   data;
    logic [`CB_DATA_W/8-1:0] be;
  } bus_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  id;
    logic                  last;
    logic [`CB_DATA_W-1:0] data;
  } bus_rbeat_t;

  typedef struct packed {
    logic valid;
    logic id;
  } bus_bresp_t;

  // back-pressure from the tid FIFOs to the issue stage
  typedef struct packed {
    logic icache_rd;
    logic dcache_rd;
    logic dcache_wr;
  } meta_full_t;

endpackage

//--- filelist.f
+incdir+.
cache_bus_pkg.sv
meta_fifo.sv
req_issue.sv
rtrn_assembler.sv
cache_bus_adapter.sv
cache_bus_adapter_props.sv
tb_cache_bus_adapter.sv

//--- meta_fifo.sv
// synchronous circular FIFO carrying any packed payload type
module meta_fifo #(
  parameter type         item_t = logic,
  parameter int unsigned depth  = 2
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  item_t data_i,
  input  logic  pop_i,
  output item_t data_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  item_t             mem_q [depth];
  logic [ptr_w-1:0]  wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0]  count_q;
  logic              do_push, do_pop;

  assign full_o  = (count_q == cnt_w'(depth));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // writes into a full FIFO and reads from an empty one are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- req_issue.sv
// round-robin issue stage choosing a cache request and encoding it for the bus
`include "cache_bus_defs.svh"

module req_issue (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  cache_bus_pkg::icache_req_t icache_head_i,
  input  logic                       icache_empty_i,
  input  cache_bus_pkg::dcache_req_t dcache_head_i,
  input  logic                       dcache_empty_i,
  input  cache_bus_pkg::meta_full_t  meta_full_i,
  output cache_bus_pkg::bus_req_t    bus_req_o,
  input  logic                       bus_gnt_i,
  output logic                       icache_pop_o,
  output logic                       dcache_pop_o,
  output logic                       issue_ird_o,
  output logic                       issue_drd_o,
  output logic                       issue_dwr_o,
  output logic [`CB_TID_W-1:0]       issue_tid_o
);

  localparam int unsigned off_w     = $clog2(`CB_DATA_W / 8);
  localparam logic [2:0]  word_size = 3'(off_w);

  logic                    ic_elig, dc_elig;
  logic                    sel, req_vld, granted;
  logic                    prio_q, lock_q, lock_idx_q;
  logic [`CB_DATA_W/8-1:0] be_mask;

  //////////////////////////////
  // arbitration
  //////////////////////////////

  // a cache competes only when its returns can still be tracked
  assign ic_elig = ~icache_empty_i & ~meta_full_i.icache_rd;
  assign dc_elig = ~dcache_empty_i & ~meta_full_i.dcache_rd & ~meta_full_i.dcache_wr;

  always_comb begin
    if (lock_q) begin
      sel = lock_idx_q;
    end else if (ic_elig && dc_elig) begin
      sel = prio_q;
    end else begin
      sel = dc_elig;
    end
  end

  assign req_vld = sel ? dc_elig : ic_elig;
  assign granted = req_vld & bus_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
    end else begin
      // hold the choice until the slave grants it
      lock_q     <= req_vld & ~bus_gnt_i;
      lock_idx_q <= sel;
      if (granted) begin
        prio_q <= ~sel;
      end
    end
  end

  //////////////////////////////
  // request encoding
  //////////////////////////////

  always_comb begin
    unique case (dcache_head_i.size[1:0])
      2'b00:   be_mask = 8'h01;
      2'b01:   be_mask = 8'h03;
      2'b10:   be_mask = 8'h0f;
      default: be_mask = 8'hff;
    endcase
  end

  always_comb begin
    bus_req_o       = '0;
    bus_req_o.valid = req_vld;
    bus_req_o.id    = sel;
    if (!sel) begin
      // instruction fill, one word when non-cacheable
      bus_req_o.addr = icache_head_i.paddr;
      bus_req_o.size = word_size;
      bus_req_o.blen = ~icache_head_i.nc;
    end else begin
      bus_req_o.addr = dcache_head_i.paddr;
      if (dcache_head_i.rtype == cache_bus_pkg::DCACHE_STORE_REQ) begin
        bus_req_o.write = 1'b1;
        bus_req_o.size  = dcache_head_i.size;
        bus_req_o.data  = dcache_head_i.data;
        bus_req_o.be    = be_mask << dcache_head_i.paddr[off_w-1:0];
      end else begin
        bus_req_o.size = dcache_head_i.size[2] ? word_size : dcache_head_i.size;
        bus_req_o.blen = dcache_head_i.size[2];
      end
    end
  end

  // pop and record the tid in the grant cycle
  assign icache_pop_o = granted & ~sel;
  assign dcache_pop_o = granted & sel;
  assign issue_ird_o  = icache_pop_o;
  assign issue_drd_o  = dcache_pop_o & ~bus_req_o.write;
  assign issue_dwr_o  = dcache_pop_o & bus_req_o.write;
  assign issue_tid_o  = sel ? dcache_head_i.tid : icache_head_i.tid;

endmodule

//--- rtrn_assembler.sv
// return path tracking tids, assembling read lines and turning write responses into acks
`include "cache_bus_defs.svh"

module rtrn_assembler (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        issue_ird_i,
  input  logic                        issue_drd_i,
  input  logic                        issue_dwr_i,
  input  logic [`CB_TID_W-1:0]        issue_tid_i,
  output cache_bus_pkg::meta_full_t   meta_full_o,
  input  cache_bus_pkg::bus_rbeat_t   bus_rbeat_i,
  input  cache_bus_pkg::bus_bresp_t   bus_bresp_i,
  output logic                        icache_rtrn_vld_o,
  output cache_bus_pkg::icache_rtrn_t icache_rtrn_o,
  output logic                        dcache_rtrn_vld_o,
  output cache_bus_pkg::dcache_rtrn_t dcache_rtrn_o
);

  localparam int unsigned words = `CB_LINE_W / `CB_DATA_W;

  typedef logic [`CB_TID_W-1:0] tid_t;
  typedef logic [words-1:0][`CB_DATA_W-1:0] line_t;

  tid_t                      ird_head, drd_head, dwr_head;
  logic                      ird_empty, drd_empty, dwr_empty;
  cache_bus_pkg::bus_bresp_t b_head;
  logic                      b_empty, b_pop;
  logic                      ic_beat, dc_beat;
  logic                      ic_vld_d, dc_vld_d, dc_rd_pop, dc_wr_pop;
  cache_bus_pkg::dcache_rtrn_e dc_rtype_d;
  line_t                     ic_line_q, dc_line_q;
  logic                      ic_first_q, dc_first_q;
  logic                      ic_vld_q, dc_vld_q;
  tid_t                      ic_tid_q, dc_tid_q;
  cache_bus_pkg::dcache_rtrn_e dc_rtype_q;

  //////////////////////////////
  // metadata FIFOs
  //////////////////////////////

  meta_fifo #(.item_t(tid_t), .depth(`CB_META_DEPTH)) u_ird_fifo (
    .clk_i, .rst_ni, .push_i(issue_ird_i), .data_i(issue_tid_i), .pop_i(ic_vld_d),
    .data_o(ird_head), .full_o(meta_full_o.icache_rd), .empty_o(ird_empty)
  );

  meta_fifo #(.item_t(tid_t), .depth(`CB_META_DEPTH)) u_drd_fifo (
    .clk_i, .rst_ni, .push_i(issue_drd_i), .data_i(issue_tid_i), .pop_i(dc_rd_pop),
    .data_o(drd_head), .full_o(meta_full_o.dcache_rd), .empty_o(drd_empty)
  );

  meta_fifo #(.item_t(tid_t), .depth(`CB_META_DEPTH)) u_dwr_fifo (
    .clk_i, .rst_ni, .push_i(issue_dwr_i), .data_i(issue_tid_i), .pop_i(dc_wr_pop),
    .data_o(dwr_head), .full_o(meta_full_o.dcache_wr), .empty_o(dwr_empty)
  );

  // write responses wait here while dcache read beats stream in
  meta_fifo #(.item_t(cache_bus_pkg::bus_bresp_t), .depth(`CB_META_DEPTH)) u_bresp_fifo (
    .clk_i, .rst_ni, .push_i(bus_bresp_i.valid), .data_i(bus_bresp_i), .pop_i(b_pop),
    .data_o(b_head), .full_o(), .empty_o(b_empty)
  );

  //////////////////////////////
  // return decode
  //////////////////////////////

  assign ic_beat = bus_rbeat_i.valid & ~bus_rbeat_i.id;
  assign dc_beat = bus_rbeat_i.valid & bus_rbeat_i.id;

  // icache channel is independent of the dcache one
  assign ic_vld_d = ic_beat & bus_rbeat_i.last & ~ird_empty;

  always_comb begin
    dc_vld_d   = 1'b0;
    dc_rd_pop  = 1'b0;
    dc_wr_pop  = 1'b0;
    b_pop      = 1'b0;
    dc_rtype_d = cache_bus_pkg::DCACHE_LOAD_ACK;
    if (dc_beat) begin
      dc_rd_pop = bus_rbeat_i.last & ~drd_empty;
      dc_vld_d  = dc_rd_pop;
    end else if (!b_empty) begin
      b_pop = 1'b1;
      // a response without the dcache id has no write tid and is dropped
      if (b_head.id && !dwr_empty) begin
        dc_wr_pop  = 1'b1;
        dc_vld_d   = 1'b1;
        dc_rtype_d = cache_bus_pkg::DCACHE_STORE_ACK;
      end
    end
  end

  //////////////////////////////
  // line assembly and outputs
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ic_first_q <= 1'b1;
      dc_first_q <= 1'b1;
      ic_vld_q   <= 1'b0;
      dc_vld_q   <= 1'b0;
    end else begin
      ic_vld_q <= ic_vld_d;
      dc_vld_q <= dc_vld_d;
      if (ic_beat) begin
        ic_first_q <= bus_rbeat_i.last;
      end
      if (dc_beat) begin
        dc_first_q <= bus_rbeat_i.last;
      end
    end
  end

  // beats enter at the top, a lone beat also lands in word 0
  always_ff @(posedge clk_i) begin
    if (ic_beat) begin
      ic_line_q <= {bus_rbeat_i.data, ic_line_q[words-1:1]};
      if (ic_first_q) begin
        ic_line_q[0] <= bus_rbeat_i.data;
      end
    end
    if (dc_beat) begin
      dc_line_q <= {bus_rbeat_i.data, dc_line_q[words-1:1]};
      if (dc_first_q) begin
        dc_line_q[0] <= bus_rbeat_i.data;
      end
    end
    if (ic_vld_d) begin
      ic_tid_q <= ird_head;
    end
    if (dc_vld_d) begin
      dc_tid_q   <= dc_wr_pop ? dwr_head : drd_head;
      dc_rtype_q <= dc_rtype_d;
    end
  end

  assign icache_rtrn_vld_o   = ic_vld_q;
  assign icache_rtrn_o.tid   = ic_tid_q;
  assign icache_rtrn_o.data  = ic_line_q;
  assign dcache_rtrn_vld_o   = dc_vld_q;
  assign dcache_rtrn_o.rtype = dc_rtype_q;
  assign dcache_rtrn_o.tid   = dc_tid_q;
  assign dcache_rtrn_o.data  = dc_line_q;

endmodule

//--- tb_cache_bus_adapter.sv
// testbench for the cache bus adapter driving a request table against a bus responder model
`include "cache_bus_defs.svh"

module tb_cache_bus_adapter;

  localparam int          n_rows   = 16;
  localparam logic [63:0] data_ofs = 64'ha5a5_0000_0000_0000;
  localparam logic        ic       = 1'b0;
  localparam logic        dc       = 1'b1;
  localparam logic        ld       = 1'b0;
  localparam logic        st       = 1'b1;

  typedef struct packed {
    logic                  port;
    logic                  rtype;
    logic [`CB_ADDR_W-1:0] paddr;
    logic                  nc;
    logic [2:0]            size;
    logic [`CB_DATA_W-1:0] data;
    logic [`CB_TID_W-1:0]  tid;
  } row_t;

  logic                        clk_i, rst_ni, bus_gnt_i;
  logic                        icache_req_i, icache_ack_o, dcache_req_i, dcache_ack_o;
  logic                        icache_rtrn_vld_o, dcache_rtrn_vld_o;
  cache_bus_pkg::icache_req_t  icache_data_i;
  cache_bus_pkg::dcache_req_t  dcache_data_i;
  cache_bus_pkg::icache_rtrn_t icache_rtrn_o;
  cache_bus_pkg::dcache_rtrn_t dcache_rtrn_o;
  cache_bus_pkg::bus_req_t     bus_req_o;
  cache_bus_pkg::bus_rbeat_t   bus_rbeat_i;
  cache_bus_pkg::bus_bresp_t   bus_bresp_i;

  // expected returns per channel in issue order
  row_t                    exp_ird[$], exp_drd[$], exp_dwr[$];
  // bus model state
  cache_bus_pkg::bus_req_t bus_wr_q[$], bus_rd_q[$], ird_req_q[$], drd_req_q[$];
  int                      bresp_due_q[$];
  logic [63:0]             mem [logic [31:0]];
  logic [15:0]             lfsr_q = 16'd99;
  int                      cyc, gnt_wait, beat_idx;
  int                      tests_ok, tests_bad, other_errs;

  // port, rtype, paddr, nc, size, data, tid
  row_t stim_table [n_rows] = '{
    '{ic, ld, 32'h0000_1000, 1'b0, 3'd3, 64'h0, 2'd0},
    '{ic, ld, 32'h0000_2008, 1'b1, 3'd3, 64'h0, 2'd1},
    '{dc, ld, 32'h0000_3010, 1'b0, 3'd3, 64'h0, 2'd0},
    '{dc, ld, 32'h0000_3020, 1'b0, 3'd7, 64'h0, 2'd1},
    '{dc, st, 32'h0000_4003, 1'b0, 3'd0, 64'h1122_3344_5566_7788, 2'd2},
    '{dc, st, 32'h0000_4006, 1'b0, 3'd1, 64'h99aa_bbcc_ddee_ff00, 2'd3},
    '{dc, st, 32'h0000_4004, 1'b0, 3'd2, 64'h0bad_cafe_1234_5678, 2'd0},
    '{dc, st, 32'h0000_4008, 1'b0, 3'd3, 64'hfeed_f00d_dead_beef, 2'd1},
    '{ic, ld, 32'h0000_1100, 1'b0, 3'd3, 64'h0, 2'd2},
    '{dc, ld, 32'h0000_3100, 1'b0, 3'd7, 64'h0, 2'd2},
    '{ic, ld, 32'h0000_1200, 1'b0, 3'd3, 64'h0, 2'd3},
    '{dc, st, 32'h0000_4010, 1'b0, 3'd3, 64'h0123_4567_89ab_cdef, 2'd2},
    '{ic, ld, 32'h0000_1300, 1'b0, 3'd3, 64'h0, 2'd0},
    '{dc, ld, 32'h0000_3204, 1'b0, 3'd2, 64'h0, 2'd3},
    '{ic, ld, 32'h0000_1408, 1'b1, 3'd3, 64'h0, 2'd1},
    '{dc, ld, 32'h0000_3300, 1'b0, 3'd7, 64'h0, 2'd0}
  };

  cache_bus_adapter u_cache_bus_adapter (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // 16 bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = (v << 1) | lfsr_q[0];
    end
  endtask

  // word k of a line is the line base plus 8k
  // a lone word is its own aligned address
  function automatic logic [63:0] line_word(input logic [31:0] a, input int k, input logic full);
    logic [31:0] base;
    base = full ? {a[31:4], 4'h0} + 32'(8 * k) : {a[31:3], 3'b000};
    return 64'(base) + data_ofs;
  endfunction

  function automatic logic [7:0] store_be(input logic [2:0] size, input logic [2:0] off);
    logic [15:0] m;
    m = (16'd1 << (1 << size[1:0])) - 16'd1;
    m = m << off;
    return m[7:0];
  endfunction

  task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] got,
                         inout int errs);
    if (exp !== got) begin
      $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
      errs++;
    end
  endtask

  task automatic report_result(input string kind, input row_t r, input int errs);
    if (errs == 0) begin
      tests_ok++;
      $display("test %s addr %h tid %0d: ok", kind, r.paddr, r.tid);
    end else begin
      tests_bad++;
      $display("test %s addr %h tid %0d: failed", kind, r.paddr, r.tid);
    end
  endtask

  task automatic check_read(input string sig, input row_t r, input cache_bus_pkg::bus_req_t w,
                            input logic [1:0] tid, input logic [127:0] line, input logic full);
    int         errs;
    logic [2:0] exp_size;
    errs = 0;
    // fills and line loads move whole 8 byte words
    exp_size = (r.port == ic || full) ? 3'd3 : r.size;
    compare("bus_req_o.size", 128'(exp_size), 128'(w.size), errs);
    compare("bus_req_o.blen", 128'(full), 128'(w.blen), errs);
    compare({sig, ".tid"}, 128'(r.tid), 128'(tid), errs);
    compare({sig, ".data[63:0]"}, 128'(line_word(r.paddr, 0, full)), 128'(line[63:0]), errs);
    if (full) begin
      compare({sig, ".data[127:64]"}, 128'(line_word(r.paddr, 1, 1'b1)), 128'(line[127:64]),
              errs);
    end
    report_result(full ? {sig, " line"} : {sig, " word"}, r, errs);
  endtask

  // hold req until ack so the request is taken at the next rising edge
  task automatic apply_row(input row_t r);
    @(negedge clk_i);
    icache_req_i  = ~r.port;
    dcache_req_i  = r.port;
    icache_data_i = '{paddr: r.paddr, nc: r.nc, tid: r.tid};
    dcache_data_i = '{rtype: cache_bus_pkg::dcache_rtype_e'(r.rtype), paddr: r.paddr,
                      size: r.size, data: r.data, tid: r.tid};
    #1;
    while (!(r.port ? dcache_ack_o : icache_ack_o)) begin
      @(negedge clk_i);
      #1;
    end
    if (!r.port) begin
      exp_ird.push_back(r);
    end else if (r.rtype == st) begin
      exp_dwr.push_back(r);
    end else begin
      exp_drd.push_back(r);
    end
  endtask

  ////////////////////////////////
  // bus responder model
  ////////////////////////////////

  initial begin : bus_model
    cache_bus_pkg::bus_req_t r;
    logic [31:0]             a;
    int                      d;
    bus_gnt_i   = 1'b0;
    bus_rbeat_i = '0;
    bus_bresp_i = '0;
    forever begin
      @(negedge clk_i);
      cyc++;
      bus_rbeat_i = '0;
      bus_bresp_i = '0;
      bus_gnt_i   = 1'b0;
      // reads one at a time with one beat per cycle
      if (bus_rd_q.size() != 0) begin
        r = bus_rd_q[0];
        a = {r.addr[31:3], 3'b000} + 32'(8 * beat_idx);
        bus_rbeat_i.valid = 1'b1;
        bus_rbeat_i.id    = r.id;
        bus_rbeat_i.data  = mem.exists(a) ? mem[a] : 64'(a) + data_ofs;
        bus_rbeat_i.last  = !r.blen || beat_idx == 1;
        beat_idx = bus_rbeat_i.last ? 0 : beat_idx + 1;
        if (bus_rbeat_i.last) begin
          void'(bus_rd_q.pop_front());
        end
      end
      if (bresp_due_q.size() != 0 && bresp_due_q[0] <= cyc) begin
        bus_bresp_i = '{valid: 1'b1, id: 1'b1};
        void'(bresp_due_q.pop_front());
      end
      if (bus_req_o.valid && gnt_wait != 0) begin
        gnt_wait--;
      end else if (bus_req_o.valid) begin
        bus_gnt_i = 1'b1;
        take_bits(2, gnt_wait);
        if (bus_req_o.write) begin
          a = {bus_req_o.addr[31:3], 3'b000};
          if (!mem.exists(a)) begin
            mem[a] = '0;
          end
          for (int b = 0; b < 8; b++) begin
            if (bus_req_o.be[b]) begin
              mem[a][8*b +: 8] = bus_req_o.data[8*b +: 8];
            end
          end
          take_bits(2, d);
          bresp_due_q.push_back(cyc + 1 + d);
          bus_wr_q.push_back(bus_req_o);
        end else begin
          bus_rd_q.push_back(bus_req_o);
          if (bus_req_o.id) begin
            drd_req_q.push_back(bus_req_o);
          end else begin
            ird_req_q.push_back(bus_req_o);
          end
        end
      end
    end
  end

  ////////////////////////////////
  // return checks
  ////////////////////////////////

  always @(negedge clk_i) begin : check_returns
    row_t                    r;
    cache_bus_pkg::bus_req_t w;
    int                      errs;
    if (icache_rtrn_vld_o && (exp_ird.size() == 0 || ird_req_q.size() == 0)) begin
      $display("error at %0t: icache return with no fill outstanding", $time);
      other_errs++;
    end else if (icache_rtrn_vld_o) begin
      r = exp_ird.pop_front();
      w = ird_req_q.pop_front();
      check_read("icache_rtrn_o", r, w, icache_rtrn_o.tid, icache_rtrn_o.data, !r.nc);
    end
    if (dcache_rtrn_vld_o && dcache_rtrn_o.rtype == cache_bus_pkg::DCACHE_STORE_ACK) begin
      if (exp_dwr.size() == 0 || bus_wr_q.size() == 0) begin
        $display("error at %0t: store ack with no store outstanding", $time);
        other_errs++;
      end else begin
        r = exp_dwr.pop_front();
        w = bus_wr_q.pop_front();
        errs = 0;
        compare("dcache_rtrn_o.tid", 128'(r.tid), 128'(dcache_rtrn_o.tid), errs);
        compare("bus_req_o.addr", 128'(r.paddr), 128'(w.addr), errs);
        compare("bus_req_o.size", 128'(r.size), 128'(w.size), errs);
        compare("bus_req_o.data", 128'(r.data), 128'(w.data), errs);
        compare("bus_req_o.be", 128'(store_be(r.size, r.paddr[2:0])), 128'(w.be), errs);
        report_result("dcache store", r, errs);
      end
    end else if (dcache_rtrn_vld_o && (exp_drd.size() == 0 || drd_req_q.size() == 0)) begin
      $display("error at %0t: dcache load return with no load outstanding", $time);
      other_errs++;
    end else if (dcache_rtrn_vld_o) begin
      r = exp_drd.pop_front();
      w = drd_req_q.pop_front();
      check_read("dcache_rtrn_o", r, w, dcache_rtrn_o.tid, dcache_rtrn_o.data, r.size[2]);
    end
  end

  initial begin : main
    rst_ni        = 1'b0;
    icache_req_i  = 1'b0;
    dcache_req_i  = 1'b0;
    icache_data_i = '0;
    dcache_data_i = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (stim_table[i]) begin
      apply_row(stim_table[i]);
    end
    @(negedge clk_i);
    icache_req_i = 1'b0;
    dcache_req_i = 1'b0;
    while (exp_ird.size() + exp_drd.size() + exp_dwr.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    $display("tests ok %0d, failed %0d, other errors %0d", tests_ok, tests_bad, other_errs);
    if (tests_bad == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (n_rows * 40) @(posedge clk_i);
    $display("error: run timed out after %0d cycles with returns missing", n_rows * 40);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
